// ==== hw/ntt_ctrl_pkg.sv ====
package ntt_ctrl_pkg;

    localparam int NUM_PASSES = 3;
    localparam int PASS_W     = (NUM_PASSES > 1) ? $clog2(NUM_PASSES) : 1;

    // butterflies issued per pass
    localparam int BU_TOTAL = 64;

    localparam int IDX_W     = 7;
    localparam int TF_ADDR_W = IDX_W + 2;

    // twiddle table row length
    localparam int TF_ROW = 64;

    // butterflies per group, one entry per pass
    localparam logic [IDX_W-1:0] GROUP_LEN [NUM_PASSES] = '{
        IDX_W'(64),
        IDX_W'(4),
        IDX_W'(32)
    };

    typedef enum logic [PASS_W-1:0] {
        PASS_0,
        PASS_1,
        PASS_2
    } pass_e;

    typedef enum logic [1:0] {
        INIT,
        RUN,
        DRAIN,
        FINISH
    } seq_state_e;

    typedef struct packed {
        pass_e            pass;
        logic [IDX_W-1:0] bu_idx;
        logic [IDX_W-1:0] group_idx;
        logic [IDX_W-1:0] tf_depth;
        logic             tf_wen;
    } bfly_cmd_t;

    // command as seen at the engine boundary
    typedef struct packed {
        bfly_cmd_t            cmd;
        logic [TF_ADDR_W-1:0] tf_addr;
    } bfly_issue_t;

endpackage

// ==== hw/ntt_pass_sequencer.sv ====
module ntt_pass_sequencer #(
    parameter int INIT_CYCLES  = 64,
    parameter int DRAIN_CYCLES = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    operand_valid,
    input  logic                    push_ready,
    input  logic                    fifo_empty,
    input  logic                    issue_idle,
    output logic                    push_valid,
    output ntt_ctrl_pkg::bfly_cmd_t push_cmd,
    output logic                    done
);
    import ntt_ctrl_pkg::*;

    localparam int INIT_W  = $clog2(INIT_CYCLES + 1);
    localparam int DRAIN_W = $clog2(DRAIN_CYCLES + 1);

    // index of the last group in each pass
    localparam logic [IDX_W-1:0] LAST_GROUP [NUM_PASSES] = '{
        IDX_W'(BU_TOTAL / GROUP_LEN[0] - 1),
        IDX_W'(BU_TOTAL / GROUP_LEN[1] - 1),
        IDX_W'(BU_TOTAL / GROUP_LEN[2] - 1)
    };

    seq_state_e         state;
    pass_e              pass;
    logic [INIT_W-1:0]  init_cnt;
    logic [DRAIN_W-1:0] drain_cnt;
    logic [IDX_W-1:0]   cmd_cnt;
    logic [IDX_W-1:0]   bu_idx;
    logic [IDX_W-1:0]   group_idx;
    logic [IDX_W-1:0]   tf_depth;
    logic               tf_wen;
    logic               push_fire;
    logic               pass_last_cmd;
    logic               group_last;
    logic               drain_ok;
    logic               drain_last;

    assign push_valid    = (state == RUN) && operand_valid;
    assign push_fire     = push_valid && push_ready;
    assign pass_last_cmd = (cmd_cnt == IDX_W'(BU_TOTAL - 1));
    assign group_last    = (bu_idx == GROUP_LEN[pass] - IDX_W'(1));

    // drain only counts once nothing is left downstream
    assign drain_ok   = fifo_empty && issue_idle;
    assign drain_last = drain_ok && (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= INIT;
            pass      <= PASS_0;
            init_cnt  <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                INIT: begin
                    if (init_cnt == INIT_W'(INIT_CYCLES - 1)) begin
                        state <= RUN;
                    end else begin
                        init_cnt <= init_cnt + 1'b1;
                    end
                end
                RUN: begin
                    if (push_fire && pass_last_cmd) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (!drain_ok) begin
                        drain_cnt <= '0;
                    end else if (drain_last) begin
                        drain_cnt <= '0;
                        if (pass == PASS_2) begin
                            state <= FINISH;
                        end else begin
                            state <= RUN;
                            pass  <= pass_e'(pass + 1'b1);
                        end
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                FINISH: begin
                    state <= FINISH;
                end
                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    // counters only move on an accepted push
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_cnt   <= '0;
            bu_idx    <= '0;
            group_idx <= '0;
        end else if (push_fire) begin
            if (pass_last_cmd) begin
                cmd_cnt   <= '0;
                bu_idx    <= '0;
                group_idx <= '0;
            end else begin
                cmd_cnt <= cmd_cnt + 1'b1;
                if (group_last) begin
                    bu_idx    <= '0;
                    group_idx <= group_idx + 1'b1;
                end else begin
                    bu_idx <= bu_idx + 1'b1;
                end
            end
        end
    end

    // pass 2 alternates depth as 2 3 3 2
    always_comb begin
        tf_depth = IDX_W'(pass);
        if (pass == PASS_2) begin
            case (cmd_cnt[1:0])
                2'd1, 2'd2: tf_depth = IDX_W'(pass) + IDX_W'(1);
                default:    tf_depth = IDX_W'(pass);
            endcase
        end
    end

    assign tf_wen = (pass != PASS_0) && group_last && (group_idx != LAST_GROUP[pass]);

    assign push_cmd = '{
        pass:      pass,
        bu_idx:    bu_idx,
        group_idx: group_idx,
        tf_depth:  tf_depth,
        tf_wen:    tf_wen
    };

    assign done = (state == FINISH);

endmodule

// ==== hw/bfly_cmd_fifo.sv ====
module bfly_cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push_valid,
    input  ntt_ctrl_pkg::bfly_cmd_t push_cmd,
    output logic                    push_ready,
    output logic                    pop_valid,
    output ntt_ctrl_pkg::bfly_cmd_t pop_cmd,
    input  logic                    pop_ready,
    output logic                    fifo_empty
);
    import ntt_ctrl_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    bfly_cmd_t       mem [FIFO_DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic [CW-1:0]   count_nxt;
    logic            full_q;
    logic            empty_q;
    logic            push_fire;
    logic            pop_fire;

    assign push_fire = push_valid && !full_q;
    assign pop_fire  = pop_ready && !empty_q;

    always_comb begin
        count_nxt = count;
        if (push_fire && !pop_fire) begin
            count_nxt = count + 1'b1;
        end else if (pop_fire && !push_fire) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count_nxt;
            full_q  <= (count_nxt == CW'(FIFO_DEPTH));
            empty_q <= (count_nxt == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    assign push_ready = !full_q;
    assign pop_valid  = !empty_q;
    assign pop_cmd    = mem[rd_ptr];
    assign fifo_empty = empty_q;

endmodule

// ==== hw/bfly_issue_stage.sv ====
module bfly_issue_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pop_valid,
    input  ntt_ctrl_pkg::bfly_cmd_t   pop_cmd,
    output logic                      pop_ready,
    output logic                      out_valid,
    output ntt_ctrl_pkg::bfly_issue_t out_cmd,
    input  logic                      out_ready,
    output logic                      issue_idle
);
    import ntt_ctrl_pkg::*;

    logic                 load;
    logic [TF_ADDR_W-1:0] tf_addr;

    // take a new command when empty or when the held one leaves
    assign pop_ready = !out_valid || out_ready;
    assign load      = pop_valid && pop_ready;

    // row of the current depth, column from the butterfly index
    assign tf_addr = TF_ADDR_W'(pop_cmd.tf_depth * TF_ROW + pop_cmd.bu_idx);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (pop_ready) begin
            out_valid <= pop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_cmd.cmd     <= pop_cmd;
            out_cmd.tf_addr <= tf_addr;
        end
    end

    assign issue_idle = !out_valid;

endmodule

// ==== hw/ntt_ctrl_top.sv ====
module ntt_ctrl_top #(
    parameter int INIT_CYCLES  = 64,
    parameter int DRAIN_CYCLES = 12,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      operand_valid,
    output logic                      out_valid,
    output ntt_ctrl_pkg::bfly_issue_t out_cmd,
    input  logic                      out_ready,
    output logic                      done
);
    import ntt_ctrl_pkg::*;

    logic      push_valid;
    logic      push_ready;
    bfly_cmd_t push_cmd;
    logic      pop_valid;
    logic      pop_ready;
    bfly_cmd_t pop_cmd;
    logic      fifo_empty;
    logic      issue_idle;

    ntt_pass_sequencer #(
        .INIT_CYCLES  (INIT_CYCLES),
        .DRAIN_CYCLES (DRAIN_CYCLES)
    ) u_seq (
        .clk           (clk),
        .rst           (rst),
        .operand_valid (operand_valid),
        .push_ready    (push_ready),
        .fifo_empty    (fifo_empty),
        .issue_idle    (issue_idle),
        .push_valid    (push_valid),
        .push_cmd      (push_cmd),
        .done          (done)
    );

    bfly_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push_valid (push_valid),
        .push_cmd   (push_cmd),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_cmd    (pop_cmd),
        .pop_ready  (pop_ready),
        .fifo_empty (fifo_empty)
    );

    bfly_issue_stage u_issue (
        .clk        (clk),
        .rst        (rst),
        .pop_valid  (pop_valid),
        .pop_cmd    (pop_cmd),
        .pop_ready  (pop_ready),
        .out_valid  (out_valid),
        .out_cmd    (out_cmd),
        .out_ready  (out_ready),
        .issue_idle (issue_idle)
    );

endmodule

// ==== sim/ntt_ctrl_tb.sv ====
module ntt_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ntt_ctrl_pkg::*;

    localparam int INIT_CYCLES  = 64;
    localparam int DRAIN_CYCLES = 12;
    localparam int FIFO_DEPTH   = 4;
    localparam int NUM_CMDS     = 192;
    localparam int CMDS_PER_PASS = 64;
    localparam int TIMEOUT_CYCLES =
        INIT_CYCLES + 4 * NUM_CMDS + 3 * (DRAIN_CYCLES + FIFO_DEPTH + 8) + 200;

    logic        clk;
    logic        rst;
    logic        operand_valid;
    logic        out_ready;
    logic        out_valid;
    bfly_issue_t out_cmd;
    logic        done;

    logic [31:0] rng_state;
    int          value_errs;
    int          protocol_errs;
    int          timeout_errs;
    int          timeout_cnt;

    // checker state
    int          cyc;
    int          n_acc;
    int          last_acc_cyc;
    logic        prev_valid;
    logic        prev_ready;
    bfly_issue_t prev_cmd;
    logic        done_seen;
    bfly_issue_t exp_cmd;

    ntt_ctrl_top #(
        .INIT_CYCLES  (INIT_CYCLES),
        .DRAIN_CYCLES (DRAIN_CYCLES),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) dut0 (
        .clk           (clk),
        .rst           (rst),
        .operand_valid (operand_valid),
        .out_valid     (out_valid),
        .out_cmd       (out_cmd),
        .out_ready     (out_ready),
        .done          (done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected command for the n-th accepted output
    function automatic bfly_issue_t expected_cmd(input int n);
        bfly_issue_t r;
        int p;
        int c;
        int glen;
        int bu;
        int grp;
        int depth;
        logic wen;
        p = n / CMDS_PER_PASS;
        c = n % CMDS_PER_PASS;
        case (p)
            0:       glen = 64;
            1:       glen = 4;
            default: glen = 32;
        endcase
        bu  = c % glen;
        grp = c / glen;
        if (p == 2) begin
            depth = ((c % 4) == 1 || (c % 4) == 2) ? 3 : 2;
        end else begin
            depth = p;
        end
        // write-back at the end of every group but the last one
        wen = (p != 0) && (bu == glen - 1) && (grp != CMDS_PER_PASS / glen - 1);
        r.cmd.pass      = pass_e'(p);
        r.cmd.bu_idx    = IDX_W'(bu);
        r.cmd.group_idx = IDX_W'(grp);
        r.cmd.tf_depth  = IDX_W'(depth);
        r.cmd.tf_wen    = wen;
        r.tf_addr       = TF_ADDR_W'(depth * 64 + bu);
        return r;
    endfunction

    task automatic drive_inputs();
        rng_state     = lcg_next(rng_state);
        operand_valid = (rng_state[31:30] != 2'b00);
        rng_state     = lcg_next(rng_state);
        out_ready     = (rng_state[31:30] != 2'b00);
    endtask

    task automatic finish_run();
        $display("error counts: value %0d, protocol %0d, timeout %0d",
                 value_errs, protocol_errs, timeout_errs);
        if (value_errs + protocol_errs + timeout_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // stimulus driven 1 ns after each rising edge
    initial begin
        rst           = 1'b1;
        operand_valid = 1'b0;
        out_ready     = 1'b0;
        rng_state     = 32'd18172;
        value_errs    = 0;
        protocol_errs = 0;
        timeout_errs  = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        drive_inputs();
        forever begin
            @(posedge clk);
            #1;
            drive_inputs();
        end
    end

    initial begin
        cyc          = 0;
        n_acc        = 0;
        last_acc_cyc = 0;
        prev_valid   = 1'b0;
        prev_ready   = 1'b0;
        prev_cmd     = '0;
        done_seen    = 1'b0;
    end

    // outputs are sampled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            cyc = cyc + 1;

            if (cyc <= INIT_CYCLES + 2) begin
                assert (!out_valid) else begin
                    $display("Error [init_wait] cycle %0d out_valid: expected 0, actual %b",
                             cyc, out_valid);
                    protocol_errs++;
                end
            end

            if (prev_valid && !prev_ready) begin
                assert (out_valid && out_cmd == prev_cmd) else begin
                    $display("Error [backpressure] cycle %0d: expected 1/%h, actual %b/%h",
                             cyc, prev_cmd, out_valid, out_cmd);
                    protocol_errs++;
                end
            end

            if (n_acc < NUM_CMDS) begin
                assert (!done) else begin
                    $display("Error [completion] done after %0d commands: expected 0, actual 1",
                             n_acc);
                    protocol_errs++;
                end
            end else begin
                assert (!out_valid) else begin
                    $display("Error [completion] cycle %0d out_valid: expected 0, actual 1", cyc);
                    protocol_errs++;
                end
            end

            if (done_seen) begin
                assert (done) else begin
                    $display("Error [completion] done fell at cycle %0d: expected 1, actual 0",
                             cyc);
                    protocol_errs++;
                end
            end

            if (out_valid && out_ready && n_acc < NUM_CMDS) begin
                exp_cmd = expected_cmd(n_acc);
                assert (out_cmd == exp_cmd) else begin
                    $display("Error [sequence] command %0d: expected %h, actual %h",
                             n_acc, exp_cmd, out_cmd);
                    value_errs++;
                end
                if (n_acc > 0 && (n_acc % CMDS_PER_PASS) == 0) begin
                    assert (cyc - last_acc_cyc >= DRAIN_CYCLES + 2) else begin
                        $display("Error [pass_gap] pass %0d: expected >= %0d cycles, actual %0d",
                                 n_acc / CMDS_PER_PASS, DRAIN_CYCLES + 2, cyc - last_acc_cyc);
                        protocol_errs++;
                    end
                end
                last_acc_cyc = cyc;
                n_acc        = n_acc + 1;
            end

            if (done) begin
                done_seen = 1'b1;
            end
            prev_valid = out_valid;
            prev_ready = out_ready;
            prev_cmd   = out_cmd;
        end
    end

    initial begin
        @(negedge rst);
        while (!done) begin
            @(negedge clk);
        end
        // watch a while longer for stray outputs
        repeat (30) @(negedge clk);
        assert (n_acc == NUM_CMDS) else begin
            $display("Error [completion] commands accepted: expected %0d, actual %0d",
                     NUM_CMDS, n_acc);
            value_errs++;
        end
        finish_run();
    end

    initial begin
        timeout_cnt = 0;
        while (timeout_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            timeout_cnt = timeout_cnt + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles, %0d commands accepted",
                 TIMEOUT_CYCLES, n_acc);
        timeout_errs++;
        finish_run();
    end

endmodule

// ==== flist.f ====
hw/ntt_ctrl_pkg.sv
hw/ntt_pass_sequencer.sv
hw/bfly_cmd_fifo.sv
hw/bfly_issue_stage.sv
hw/ntt_ctrl_top.sv
sim/ntt_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the NTT control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f flist.f --top-module ntt_ctrl_tb -o ntt_ctrl_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/ntt_ctrl_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
